/* filelist.f */
logic/tester_pkg.sv
logic/display_pkg.sv
logic/program_rom.sv
logic/test_sequencer.sv
logic/message_scroller.sv
logic/cpu_tester.sv
sim/tb_cpu_tester.sv

/* sim/tb_cpu_tester.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_tester import tester_pkg::*, display_pkg::*;
();

	localparam int cycle_limit = 40;
	localparam int scroll_div = 3;

	logic        clk;
	logic        areset;
	logic [2:0]  btn;
	byte_t       imem_addr;
	byte_t       tb_data;
	byte_t       imem_data;
	logic        green_light;
	logic        orange_light;
	logic        red_light;
	digits_t     disp;

	// Reference state of the tester as of the last rising edge
	bit          run_done;
	int          cyc_cnt;
	int          probe_k;
	int          err_cnt;
	int          tick_cnt;
	int          scroll_off;
	int          edges;
	int          level_sel;
	logic [15:0] lfsr;

	cpu_tester #(.cycle_limit(cycle_limit), .scroll_div(scroll_div)) i_cpu_tester
	(
		.clk          (clk),
		.areset       (areset),
		.btn          (btn),
		.imem_addr    (imem_addr),
		.tb_data      (tb_data),
		.imem_data    (imem_data),
		.green_light  (green_light),
		.orange_light (orange_light),
		.red_light    (red_light),
		.disp         (disp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// Taps 16 14 13 11
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++)
		begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic glyph_t seg_pattern(input int d);
		case (d)
			0: return 7'h7E;
			1: return 7'h30;
			2: return 7'h6D;
			3: return 7'h79;
			4: return 7'h33;
			5: return 7'h5B;
			6: return 7'h5F;
			7: return 7'h72;
			8: return 7'h7F;
			9: return 7'h7B;
			default: return 7'h00;
		endcase
	endfunction

	// Hand-assembled level programs
	function automatic byte_t prog_ref(input int lvl, input int addr);
		if (addr >= 32)
			return 8'hC0;
		if (lvl == 0)
			case (addr)
				0: return 8'hF0;
				1: return 8'h44;
				2: return 8'h64;
				3, 4, 5, 6, 7: return 8'hD0;
				8, 9: return 8'hD2;
				10: return 8'h88;
				11: return 8'h48;
				default: return 8'h00;
			endcase
		if (lvl == 1)
			case (addr)
				0, 1: return 8'hF0;
				2: return 8'h44;
				3: return 8'h0D;
				10: return 8'h48;
				15: return 8'h01;
				16: return 8'h64;
				17, 18, 19, 20, 21: return 8'hD0;
				22, 24: return 8'hDA;
				23: return 8'hD2;
				25: return 8'h88;
				26: return 8'h30;
				default: return 8'h00;
			endcase
		case (addr)
			1: return 8'h41;
			2: return 8'h50;
			3: return 8'h65;
			4: return 8'hD9;
			5: return 8'h7A;
			6: return 8'hDE;
			7: return 8'h89;
			8, 10: return 8'hDB;
			9: return 8'hA1;
			11: return 8'hD5;
			12: return 8'hE9;
			13: return 8'hA4;
			14: return 8'hD8;
			15: return 8'hA5;
			16: return 8'h6D;
			17: return 8'h99;
			18: return 8'h75;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic byte_t exp_ref(input int lvl, input int idx);
		int n;
		byte_t v;
		n = idx + 1;
		v = byte_t'((n / 10) * 16 + n % 10);	// BCD of idx+1
		if (lvl == 0 && idx == 1)
			v = 8'h22;
		if (lvl == 1 && idx == 4)
			v = 8'h22;
		if (lvl == 2)
			case (idx)
				3: v = 8'h17;
				6: v = 8'h20;
				7: v = 8'h22;
				9: v = 8'h02;
				24: v = 8'h06;
				default: ;
			endcase
		return v;
	endfunction

	function automatic byte_t probe_ref(input int k);
		if (k >= 64)
			return 8'hC0;
		if (k % 2 == 0)
			return (k < 2) ? 8'hE0 : 8'hD1;
		return (k < 2) ? 8'h50 : 8'h60;
	endfunction

	function automatic glyph_t msg_ref(input int lvl, input int errs, input int idx);
		glyph_t pass_msg [16];
		glyph_t fail_msg [16];
		int tens;
		int units;
		tens = errs / 10;
		if (tens > 3)
			tens = 3;
		units = (errs - 10 * tens) & 15;
		pass_msg = '{7'h0E, 7'h4F, 7'h1E, 7'h4F, 7'h0E, 7'h00, seg_pattern(lvl), 7'h00,
			7'h67, 7'h77, 7'h5B, 7'h5B, 7'h4F, 7'h3D, 7'h08, 7'h00};
		fail_msg = '{7'h0E, seg_pattern(lvl), 7'h00, 7'h47, 7'h77, 7'h06, 7'h0E, 7'h4F,
			7'h3D, 7'h08, 7'h08, 7'h4E, seg_pattern(tens), seg_pattern(units), 7'h78, 7'h00};
		if (errs != 0)
			return fail_msg[idx];
		else
			return pass_msg[idx];
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual,
				expected));
	endtask

	// Advance the reference by one edge and check the registered outputs
	task automatic step_cycle();
		digits_t want;
		logic load;
		int mask;
		load = (tick_cnt == scroll_div);
		mask = run_done ? 15 : 7;
		for (int i = 0; i < 6; i++)
			want[i] = msg_ref(level_sel, err_cnt, (scroll_off + i) & mask);
		if (load)
		begin
			tick_cnt = 0;
			scroll_off = (scroll_off + 1) & mask;
		end
		else
			tick_cnt++;
		if (run_done)
		begin
			if (probe_k % 2 == 1 && tb_data != exp_ref(level_sel, probe_k / 2))
				err_cnt = (err_cnt + 1) & 255;
			if (probe_k < 64)
				probe_k++;
		end
		else if (tb_data == 8'h22 || cyc_cnt == cycle_limit)
			run_done = 1'b1;
		else
			cyc_cnt++;
		@(posedge clk);
		@(negedge clk);
		edges++;
		if (load)
			check_value("disp", disp, want);
		check_value("orange_light", orange_light, !run_done);
		check_value("red_light", red_light, err_cnt != 0);
		check_value("green_light", green_light, !(run_done && err_cnt != 0));
	endtask

	task automatic apply_reset(input int lvl);
		areset = 1'b1;
		btn = (lvl == 0) ? 3'b111 : ((lvl == 1) ? 3'b110 : 3'b100);	// Extra buttons test priority
		imem_addr = 8'h00;
		tb_data = 8'h00;
		repeat (8)
		begin
			@(posedge clk);
			@(negedge clk);
		end
		areset = 1'b0;
		btn = 3'b000;	// Level must stay latched
		level_sel = lvl;
		run_done = 1'b0;
		cyc_cnt = 0;
		probe_k = 0;
		err_cnt = 0;
		tick_cnt = 0;
		scroll_off = 0;
		edges = 0;
		check_value("disp", disp, 0);
		check_value("orange_light", orange_light, 1'b1);
		check_value("green_light", green_light, 1'b1);
		check_value("red_light", red_light, 1'b0);
	endtask

	task automatic fetch_cycle();
		byte_t addr;
		addr = byte_t'(rand_bits(6));
		imem_addr = addr;
		tb_data = 8'h00;
		#1;
		check_value("imem_data", imem_data, prog_ref(level_sel, addr));
		step_cycle();
	endtask

	// Answer the odd probes and spoil exactly n_bad of the 32 reads
	task automatic run_probes(input int n_bad);
		int done;
		int guard;
		byte_t data;
		done = 0;
		guard = 0;
		while (probe_k < 64 && guard < 100)
		begin
			guard++;
			data = 8'h00;
			if (probe_k % 2 == 1)
			begin
				data = exp_ref(level_sel, probe_k / 2);
				if (done < n_bad && (n_bad - done >= 32 - probe_k / 2 || rand_bits(2) == 0))
				begin
					data = data ^ 8'h5A;
					done++;
				end
			end
			tb_data = data;
			imem_addr = 8'h00;
			#1;
			check_value("imem_data", imem_data, probe_ref(probe_k));
			step_cycle();
		end
		if (probe_k < 64)
			abort_run("timeout waiting for the probe sequence to finish");
	endtask

	initial
	begin
		int n_bad;
		int guard;
		areset = 1'b1;
		btn = 3'b000;
		imem_addr = 8'h00;
		tb_data = 8'h00;
		lfsr = 16'd78;
		@(negedge clk);
		for (int lvl = 0; lvl < 3; lvl++)
		begin
			apply_reset(lvl);
			if (lvl == 0)
			begin
				repeat (20) fetch_cycle();
				tb_data = done_marker;
				imem_addr = 8'h00;
				step_cycle();
				check_value("orange_light", orange_light, 1'b0);
				tb_data = 8'h00;
				#1;
				check_value("imem_data", imem_data, 8'hE0);
			end
			else
			begin
				guard = 0;
				while (orange_light && guard < 100)
				begin
					fetch_cycle();
					guard++;
				end
				if (orange_light)
					abort_run("timeout waiting for the run phase to end");
				check_value("run phase edges", edges, cycle_limit + 1);
			end
			n_bad = (lvl == 0) ? 0 : 1 + rand_bits(4) % 12;
			run_probes(n_bad);
			tb_data = 8'h00;
			#1;
			check_value("imem_data", imem_data, 8'hC0);
			check_value("red_light", red_light, n_bad != 0);
			check_value("green_light", green_light, n_bad == 0);
			repeat (80) step_cycle();	// Every message offset at least once
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/cpu_tester.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tester import tester_pkg::*, display_pkg::*;
#(
	parameter int cycle_limit = 100,
	parameter int scroll_div = 24999999
)
(
	input  wire        clk,
	input  wire        areset,
	input  wire [2:0]  btn,
	input  byte_t      imem_addr,
	input  byte_t      tb_data,
	output byte_t      imem_data,
	output logic       green_light,
	output logic       orange_light,
	output logic       red_light,
	output digits_t    disp
);

	level_e         level;
	byte_t          prog_data;
	byte_t          expected;
	logic [4:0]     exp_index;
	tester_status_t status;

	// Buttons sampled only while held in reset
	always_ff @(posedge clk)
	begin
		if (areset)
			level <= btn[0] ? level_0 : (btn[1] ? level_1 : level_2);
	end

	program_rom i_program_rom
	(
		.clk       (clk),
		.areset    (areset),
		.level     (level),
		.imem_addr (imem_addr),
		.exp_index (exp_index),
		.prog_data (prog_data),
		.expected  (expected)
	);

	test_sequencer #(.cycle_limit(cycle_limit)) i_test_sequencer
	(
		.clk          (clk),
		.areset       (areset),
		.level        (level),
		.tb_data      (tb_data),
		.prog_data    (prog_data),
		.expected     (expected),
		.exp_index    (exp_index),
		.imem_data    (imem_data),
		.green_light  (green_light),
		.orange_light (orange_light),
		.red_light    (red_light),
		.status       (status)
	);

	message_scroller #(.scroll_div(scroll_div)) i_message_scroller
	(
		.clk    (clk),
		.areset (areset),
		.status (status),
		.disp   (disp)
	);

endmodule

`default_nettype wire

/* logic/message_scroller.sv */
`timescale 1ns/1ps
`default_nettype none

module message_scroller import tester_pkg::*, display_pkg::*;
#(
	parameter int scroll_div = 24999999
)
(
	input  wire            clk,
	input  wire            areset,
	input  tester_status_t status,
	output digits_t        disp
);

	localparam int cnt_w = (scroll_div > 0) ? $clog2(scroll_div + 1) : 1;

	logic [cnt_w-1:0] tick_cnt;
	logic [3:0]       offset;
	logic [3:0]       mask;
	logic [3:0]       tens;
	byte_t            units;
	glyph_t           level_glyph;
	glyph_t           tens_glyph;
	glyph_t           units_glyph;
	glyph_t           msg [msg_len];

	always_comb
	begin
		if (status.n_errors < 8'd10)
			tens = 4'd0;
		else if (status.n_errors < 8'd20)
			tens = 4'd1;
		else if (status.n_errors < 8'd30)
			tens = 4'd2;
		else
			tens = 4'd3;	// Capped
	end

	assign units = status.n_errors - {4'd0, tens} * 8'd10;

	assign level_glyph = to_glyph({1'b0, status.level});
	assign tens_glyph = to_glyph(tens);
	assign units_glyph = to_glyph(units[3:0]);

	always_comb
	begin
		if (status.n_errors != '0)
			msg = '{7'h0E, level_glyph, 7'h00, 7'h47, 7'h77, 7'h06, 7'h0E, 7'h4F,
				7'h3D, 7'h08, 7'h08, 7'h4E, tens_glyph, units_glyph, 7'h78, 7'h00};
		else
			msg = '{7'h0E, 7'h4F, 7'h1E, 7'h4F, 7'h0E, 7'h00, level_glyph, 7'h00,
				7'h67, 7'h77, 7'h5B, 7'h5B, 7'h4F, 7'h3D, 7'h08, 7'h00};
	end

	// Short window while the CPU runs
	assign mask = (status.phase == phase_check) ? 4'(msg_len - 1) : 4'd7;

	always_ff @(posedge clk)
	begin
		if (areset)
		begin
			tick_cnt <= '0;
			offset <= '0;
			disp <= {6{blank_glyph}};
		end
		else if (tick_cnt == cnt_w'(scroll_div))
		begin
			tick_cnt <= '0;
			offset <= (offset + 4'd1) & mask;
			for (int i = 0; i < 6; i++)
				disp[i] <= msg[(offset + 4'(i)) & mask];
		end
		else
		begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/test_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module test_sequencer import tester_pkg::*;
#(
	parameter int cycle_limit = 100
)
(
	input  wire            clk,
	input  wire            areset,
	input  level_e         level,
	input  byte_t          tb_data,
	input  byte_t          prog_data,
	input  byte_t          expected,
	output logic [4:0]     exp_index,
	output byte_t          imem_data,
	output logic           green_light,
	output logic           orange_light,
	output logic           red_light,
	output tester_status_t status
);

	phase_e     phase;
	byte_t      cycle_cnt;
	logic [6:0] probe_cnt;	// Saturates at 64
	byte_t      n_errors;
	instr_t     probe;
	logic       first_pair;

	always_ff @(posedge clk)
	begin
		if (areset)
		begin
			phase <= phase_run;
			cycle_cnt <= '0;
			probe_cnt <= '0;
			n_errors <= '0;
		end
		else if (phase == phase_check)
		begin
			if (probe_cnt[0] && (tb_data != expected))
				n_errors <= n_errors + 8'd1;	// Wraps
			if (!probe_cnt[6])
				probe_cnt <= probe_cnt + 7'd1;
		end
		else if ((tb_data == done_marker) || (cycle_cnt == byte_t'(cycle_limit)))
		begin
			phase <= phase_check;
		end
		else
		begin
			cycle_cnt <= cycle_cnt + 8'd1;
		end
	end

	assign first_pair = (probe_cnt < 7'd2);

	// Even probes do r0 arithmetic, odd probes read a register back
	always_comb
	begin
		probe = instr_t'(nop_instr);
		if (!probe_cnt[6])
		begin
			if (probe_cnt[0])
				probe = '{opcode: op_load, ra: first_pair ? 2'd1 : 2'd2,
					rb: 2'd0, imm: 2'd0};
			else
				probe = '{opcode: op_arith, ra: first_pair ? alu_sub : alu_add,
					rb: 2'd0, imm: first_pair ? 2'd0 : 2'd1};
		end
	end

	assign exp_index = probe_cnt[5:1];
	assign imem_data = (phase == phase_check) ? byte_t'(probe) : prog_data;

	assign orange_light = (phase == phase_run);
	assign red_light = (n_errors != '0);
	assign green_light = !((phase == phase_check) && red_light);

	assign status = '{phase: phase, level: level, n_errors: n_errors};

endmodule

`default_nettype wire

/* logic/program_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module program_rom import tester_pkg::*;
(
	input  wire         clk,
	input  wire         areset,
	input  level_e      level,
	input  byte_t       imem_addr,
	input  wire [4:0]   exp_index,
	output byte_t       prog_data,
	output byte_t       expected
);

	localparam logic [1:0] r0 = 2'd0;
	localparam logic [1:0] r1 = 2'd1;
	localparam logic [1:0] r2 = 2'd2;
	localparam logic [1:0] r3 = 2'd3;

	function automatic byte_t mem_op(opcode_e op, logic [1:0] ra, logic [1:0] rb,
		logic [1:0] imm);
		instr_t i;
		i = '{opcode: op, ra: ra, rb: rb, imm: imm};
		return i;
	endfunction

	function automatic byte_t alu_op(alu_e fn, logic [1:0] rd, logic [1:0] rs);
		instr_t i;
		i = '{opcode: op_arith, ra: fn, rb: rd, imm: rs};
		return i;
	endfunction

	function automatic byte_t jump(logic [5:0] target);
		instr_t i;
		i = '{opcode: op_jmp, ra: target[5:4], rb: target[3:2], imm: target[1:0]};
		return i;
	endfunction

	function automatic byte_t prog_byte(level_e lvl, logic [4:0] addr);
		case (lvl)
			level_0:
				case (addr)
					5'd0:                      return alu_op(alu_nop, r0, r0);
					5'd1:                      return mem_op(op_load, r0, r1, 2'd0);
					5'd2:                      return mem_op(op_load, r2, r1, 2'd0);
					5'd3, 5'd4, 5'd5, 5'd6, 5'd7: return alu_op(alu_add, r0, r0);
					5'd8, 5'd9:                return alu_op(alu_add, r0, r2);
					5'd10:                     return mem_op(op_store, r0, r2, 2'd0);
					5'd11:                     return mem_op(op_load, r0, r2, 2'd0);
					default:                   return jump(6'h00);
				endcase
			level_1:
				case (addr)
					5'd0, 5'd1:                return alu_op(alu_nop, r0, r0);
					5'd2:                      return mem_op(op_load, r0, r1, 2'd0);
					5'd3:                      return jump(6'h0d);	// Skip the dead block
					5'd10:                     return mem_op(op_load, r0, r2, 2'd0);
					5'd15:                     return jump(6'h01);
					5'd16:                     return mem_op(op_load, r2, r1, 2'd0);
					5'd17, 5'd18, 5'd19, 5'd20, 5'd21: return alu_op(alu_add, r0, r0);
					5'd22, 5'd24:              return alu_op(alu_add, r2, r2);
					5'd23:                     return alu_op(alu_add, r0, r2);
					5'd25:                     return mem_op(op_store, r0, r2, 2'd0);
					5'd26:                     return jump(6'h30);
					default:                   return jump(6'h00);
				endcase
			default:
				case (addr)
					5'd1:        return mem_op(op_load, r0, r0, 2'd1);
					5'd2:        return mem_op(op_load, r1, r0, 2'd0);
					5'd3:        return mem_op(op_load, r2, r1, 2'd1);
					5'd4:        return alu_op(alu_add, r2, r1);
					5'd5:        return mem_op(op_load, r3, r2, 2'd2);
					5'd6:        return alu_op(alu_add, r3, r2);
					5'd7:        return mem_op(op_store, r0, r2, 2'd1);
					5'd8, 5'd10: return alu_op(alu_add, r2, r3);
					5'd9:        return mem_op(op_store, r2, r0, 2'd1);
					5'd11:       return alu_op(alu_add, r1, r1);
					5'd12:       return alu_op(alu_sub, r2, r1);
					5'd13:       return mem_op(op_store, r2, r1, 2'd0);
					5'd14:       return alu_op(alu_add, r2, r0);
					5'd15:       return mem_op(op_store, r2, r1, 2'd1);
					5'd16:       return mem_op(op_load, r2, r3, 2'd1);
					5'd17:       return mem_op(op_store, r1, r2, 2'd1);
					5'd18:       return mem_op(op_load, r3, r1, 2'd1);
					default:     return alu_op(alu_nop, r3, r3);	// 0xFF filler
				endcase
		endcase
	endfunction

	// Table is index+1 in BCD, with a few per-level deviations
	function automatic byte_t exp_value(level_e lvl, logic [4:0] idx);
		logic [5:0] n;
		byte_t v;
		n = 6'(idx) + 6'd1;
		v = {4'(n / 6'd10), 4'(n % 6'd10)};
		case (lvl)
			level_0: if (idx == 5'd1) v = 8'h22;
			level_1: if (idx == 5'd4) v = 8'h22;
			default:
				case (idx)
					5'd3:  v = 8'h17;
					5'd6:  v = 8'h20;
					5'd7:  v = 8'h22;
					5'd9:  v = 8'h02;
					5'd24: v = 8'h06;
					default: ;
				endcase
		endcase
		return v;
	endfunction

	always_comb
	begin
		prog_data = nop_instr;	// Above the program area
		if (imem_addr < byte_t'(prog_depth))
			prog_data = prog_byte(level, imem_addr[4:0]);
	end

	// Read one cycle ahead of the odd-probe compare
	always_ff @(posedge clk)
	begin
		if (areset)
			expected <= '0;
		else
			expected <= exp_value(level, exp_index);
	end

endmodule

`default_nettype wire

/* logic/display_pkg.sv */
`default_nettype none

package display_pkg;

	// Segment a on bit 6 down to g on bit 0, lit when 1
	typedef logic [6:0] glyph_t;

	typedef glyph_t [0:5] digits_t;	// Digit 0 leftmost

	localparam int msg_len = 16;

	localparam glyph_t blank_glyph = 7'h00;

	function automatic glyph_t to_glyph(input logic [3:0] value);
		case (value)
			4'd0:    return 7'h7E;
			4'd1:    return 7'h30;
			4'd2:    return 7'h6D;
			4'd3:    return 7'h79;
			4'd4:    return 7'h33;
			4'd5:    return 7'h5B;
			4'd6:    return 7'h5F;
			4'd7:    return 7'h72;
			4'd8:    return 7'h7F;
			4'd9:    return 7'h7B;
			default: return blank_glyph;
		endcase
	endfunction

endpackage

`default_nettype wire

/* logic/tester_pkg.sv */
`default_nettype none

package tester_pkg;

	localparam int data_width = 8;
	localparam int prog_depth = 32;	// Program bytes per level

	typedef logic [data_width-1:0] byte_t;

	typedef enum logic [1:0]
	{
		op_jmp   = 2'd0,
		op_load  = 2'd1,
		op_store = 2'd2,
		op_arith = 2'd3
	} opcode_e;

	// ALU function, carried in the ra field of arith instructions
	typedef enum logic [1:0]
	{
		alu_add = 2'd1,
		alu_sub = 2'd2,
		alu_nop = 2'd3
	} alu_e;

	typedef struct packed
	{
		opcode_e    opcode;
		logic [1:0] ra;
		logic [1:0] rb;
		logic [1:0] imm;
	} instr_t;

	typedef enum logic [2:0]
	{
		level_0 = 3'd0,
		level_1 = 3'd1,
		level_2 = 3'd2
	} level_e;

	typedef enum logic
	{
		phase_run   = 1'b0,
		phase_check = 1'b1
	} phase_e;

	localparam byte_t done_marker = 8'h22;	// Written by the CPU when finished
	localparam byte_t nop_instr = 8'hC0;

	typedef struct packed
	{
		phase_e phase;
		level_e level;
		byte_t  n_errors;
	} tester_status_t;

endpackage

`default_nettype wire
